// ==== logic/xgmii_pkg.sv ====
`default_nettype none

package xgmii_pkg;

    // XGMII control characters
    localparam logic [7:0] IDLE_CODE  = 8'h07;
    localparam logic [7:0] START_CODE = 8'hFB;
    localparam logic [7:0] TERM_CODE  = 8'hFD;
    localparam logic [7:0] ERROR_CODE = 8'hFE;

    // Ethernet payload limits and minimum inter-frame gap, in bytes
    localparam int MIN_PAYLOAD_BYTES = 46;
    localparam int MAX_PAYLOAD_BYTES = 1500;
    localparam int MIN_GAP_BYTES     = 12;

    localparam int LEN_W  = 12;    // Byte count width
    localparam int STAT_W = 16;    // Statistics counter width

    typedef enum logic [7:0] {
        CODE_IDLE  = IDLE_CODE,
        CODE_START = START_CODE,
        CODE_TERM  = TERM_CODE,
        CODE_ERROR = ERROR_CODE
    } xgmii_code_e;

    // Lane k is txd[8k+7:8k] with txc[k]
    typedef struct packed {
        logic [63:0] txd;
        logic [7:0]  txc;
    } xgmii_word_t;

    localparam xgmii_word_t IDLE_WORD = '{txd: {8{IDLE_CODE}}, txc: 8'hFF};

    typedef struct packed {
        logic [LEN_W-1:0] len;      // Payload bytes
        logic [7:0]       gap;      // Minimum idle bytes after the frame
        logic [7:0]       seed;     // First payload byte
        logic             bad_code; // Error code in last payload lane
    } frame_req_t;

    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic             len_err;
        logic             code_err;
        logic             gap_err;  // Verdict on the gap before this frame
    } frame_report_t;

    typedef struct packed {
        logic [STAT_W-1:0] frames;
        logic [STAT_W-1:0] len_errs;
        logic [STAT_W-1:0] gap_errs;
        logic [STAT_W-1:0] code_errs;
    } link_stats_t;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_DATA,
        GEN_GAP
    } gen_state_e;

    typedef enum logic [1:0] {
        CHK_WAIT_START,
        CHK_COUNT_DATA,
        CHK_CHECK_GAP
    } chk_state_e;

endpackage

`default_nettype wire

// ==== logic/xgmii_frame_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_frame_gen (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  xgmii_pkg::frame_req_t  i_req,
    output logic                   o_busy,
    output xgmii_pkg::xgmii_word_t o_xgmii
);
    import xgmii_pkg::*;

    gen_state_e       state;
    gen_state_e       nxt_state;
    frame_req_t       req_q;
    frame_req_t       req_sel;
    logic [LEN_W-1:0] pos;          // Payload index of lane 0 in the next data word
    logic [LEN_W-1:0] pos_base;
    logic [LEN_W-1:0] nxt_pos;
    logic [8:0]       idles;        // Idle bytes sent since the terminate
    logic [8:0]       idles_sum;
    logic [8:0]       nxt_idles;
    logic             first;
    logic [LEN_W:0]   p;
    logic             term_in_word;
    logic [3:0]       tail;
    logic             frame_word;
    xgmii_word_t      word;

    assign o_busy = (state != GEN_IDLE);

    // In IDLE the request is taken straight from the port so the start word
    // goes out on the sampling edge
    assign first    = (state == GEN_IDLE);
    assign req_sel  = first ? i_req : req_q;
    assign pos_base = first ? '0 : pos;

    // Lane assembly
    always_comb begin
        word         = IDLE_WORD;
        term_in_word = 1'b0;
        tail         = '0;
        p            = '0;
        for (int k = 0; k < 8; k++) begin
            p = {1'b0, pos_base} + (LEN_W+1)'(k) - (LEN_W+1)'(first);
            if (first && k == 0) begin
                word.txd[7:0] = CODE_START;
                word.txc[0]   = 1'b1;
            end else if (p < {1'b0, req_sel.len}) begin
                if (req_sel.bad_code && p == {1'b0, req_sel.len} - 1'b1) begin
                    word.txd[8*k +: 8] = CODE_ERROR;  // Injected error
                    word.txc[k]        = 1'b1;
                end else begin
                    word.txd[8*k +: 8] = req_sel.seed + p[7:0];
                    word.txc[k]        = 1'b0;
                end
            end else if (p == {1'b0, req_sel.len}) begin
                word.txd[8*k +: 8] = CODE_TERM;
                word.txc[k]        = 1'b1;
                term_in_word       = 1'b1;
            end else begin
                tail = tail + 1'b1;  // Lane stays idle
            end
        end
    end

    assign frame_word = (state == GEN_DATA) || (first && i_req_valid);
    assign idles_sum  = idles + 9'd8;

    always_comb begin
        nxt_state = state;
        nxt_pos   = pos;
        nxt_idles = idles;
        case (state)
            GEN_IDLE, GEN_DATA: begin
                if (frame_word) begin
                    if (term_in_word) begin
                        if ({5'd0, tail} >= {1'b0, req_sel.gap}) begin
                            nxt_state = GEN_IDLE;  // Trailing lanes cover the gap
                        end else begin
                            nxt_state = GEN_GAP;
                            nxt_idles = {5'd0, tail};
                        end
                    end else begin
                        nxt_state = GEN_DATA;
                        nxt_pos   = pos_base + (first ? LEN_W'(7) : LEN_W'(8));
                    end
                end
            end
            GEN_GAP: begin
                if (idles_sum >= {1'b0, req_q.gap}) begin
                    nxt_state = GEN_IDLE;
                end else begin
                    nxt_idles = idles_sum;
                end
            end
            default: nxt_state = GEN_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= GEN_IDLE;
            pos     <= '0;
            idles   <= '0;
            o_xgmii <= IDLE_WORD;
        end else begin
            state   <= nxt_state;
            pos     <= nxt_pos;
            idles   <= nxt_idles;
            o_xgmii <= frame_word ? word : IDLE_WORD;
        end
    end

    always_ff @(posedge clk) begin
        if (first && i_req_valid) begin
            req_q <= i_req;
        end
    end

endmodule

`default_nettype wire

// ==== logic/xgmii_frame_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_frame_checker (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  xgmii_pkg::xgmii_word_t   i_xgmii,
    output logic                     o_report_valid,
    output xgmii_pkg::frame_report_t o_report
);
    import xgmii_pkg::*;

    chk_state_e       state;
    logic [LEN_W-1:0] pay_cnt;      // Payload bytes so far
    logic [LEN_W-1:0] gap_cnt;      // Idle bytes since the last terminate
    logic             code_err_q;   // Code errors pending for the next report
    logic             gap_err_q;    // Gap verdict held for the current frame

    xgmii_code_e      lane_code;
    logic             start_hit;
    logic             scan_on;
    logic             first_lane;
    logic             term_seen;
    logic             word_err;
    logic             gap_bad;
    logic [3:0]       data_bytes;
    logic [3:0]       tail_idles;
    logic [3:0]       gap_bytes;
    logic [LEN_W:0]   pay_sum;
    logic [LEN_W-1:0] pay_tot;
    logic [LEN_W:0]   gap_sum;
    logic [LEN_W-1:0] gap_tot;
    logic             gap_short;
    logic             err_sum;

    // Start is legal in lane 0 only
    assign start_hit = i_xgmii.txc[0] && (state != CHK_COUNT_DATA) &&
                       (xgmii_code_e'(i_xgmii.txd[7:0]) == CODE_START);
    assign scan_on    = (state == CHK_COUNT_DATA) || start_hit;
    assign first_lane = start_hit;

    // Lane scan of the current word
    always_comb begin
        lane_code  = CODE_IDLE;
        term_seen  = 1'b0;
        word_err   = 1'b0;
        gap_bad    = 1'b0;
        data_bytes = '0;
        tail_idles = '0;
        gap_bytes  = '0;
        for (int k = 0; k < 8; k++) begin
            lane_code = xgmii_code_e'(i_xgmii.txd[8*k +: 8]);
            if (!scan_on) begin
                if (i_xgmii.txc[k] && lane_code == CODE_IDLE) begin
                    gap_bytes = gap_bytes + 1'b1;
                end else begin
                    gap_bad = 1'b1;  // Data or stray control in the gap
                end
            end else if (k >= 32'(first_lane)) begin
                if (term_seen) begin
                    if (i_xgmii.txc[k] && lane_code == CODE_IDLE) begin
                        tail_idles = tail_idles + 1'b1;
                    end else begin
                        word_err = 1'b1;
                    end
                end else if (i_xgmii.txc[k]) begin
                    if (lane_code == CODE_TERM) begin
                        term_seen = 1'b1;
                    end else begin
                        word_err   = 1'b1;  // Control inside the payload
                        data_bytes = data_bytes + 1'b1;
                    end
                end else begin
                    data_bytes = data_bytes + 1'b1;
                end
            end
        end
    end

    // Byte counts saturate rather than wrap
    assign pay_sum = (start_hit ? '0 : {1'b0, pay_cnt}) + {{(LEN_W-3){1'b0}}, data_bytes};
    assign pay_tot = pay_sum[LEN_W] ? '1 : pay_sum[LEN_W-1:0];
    assign gap_sum = {1'b0, gap_cnt} + {{(LEN_W-3){1'b0}}, gap_bytes};
    assign gap_tot = gap_sum[LEN_W] ? '1 : gap_sum[LEN_W-1:0];

    // No gap to judge before the first frame after reset
    assign gap_short = (state == CHK_CHECK_GAP) && (gap_cnt < MIN_GAP_BYTES);
    assign err_sum   = code_err_q | word_err;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= CHK_WAIT_START;
            pay_cnt        <= '0;
            gap_cnt        <= '0;
            code_err_q     <= 1'b0;
            gap_err_q      <= 1'b0;
            o_report_valid <= 1'b0;
        end else begin
            o_report_valid <= scan_on && term_seen;
            if (start_hit) begin
                gap_err_q <= gap_short;
            end
            if (scan_on) begin
                if (term_seen) begin
                    state      <= CHK_CHECK_GAP;
                    pay_cnt    <= '0;
                    gap_cnt    <= LEN_W'(tail_idles);
                    code_err_q <= 1'b0;
                end else begin
                    state      <= CHK_COUNT_DATA;
                    pay_cnt    <= pay_tot;
                    code_err_q <= err_sum;
                end
            end else if (state == CHK_CHECK_GAP) begin
                gap_cnt <= gap_tot;
                if (gap_bad) begin
                    code_err_q <= 1'b1;  // Charged to the next frame
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_on && term_seen) begin
            o_report.len      <= pay_tot;
            o_report.len_err  <= (pay_tot < MIN_PAYLOAD_BYTES) ||
                                 (pay_tot > MAX_PAYLOAD_BYTES);
            o_report.code_err <= err_sum;
            o_report.gap_err  <= start_hit ? gap_short : gap_err_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/xgmii_link_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_link_stats (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_report_valid,
    input  xgmii_pkg::frame_report_t i_report,
    output xgmii_pkg::link_stats_t   o_stats
);
    import xgmii_pkg::*;

    link_stats_t stats;
    link_stats_t nxt_stats;

    // Saturating increment, holds at all ones
    function automatic logic [STAT_W-1:0] sat_inc(
        input logic [STAT_W-1:0] v,
        input logic              en
    );
        logic [STAT_W-1:0] r;
        r = v;
        if (en && v != '1) begin
            r = v + 1'b1;
        end
        return r;
    endfunction

    always_comb begin
        nxt_stats = stats;
        if (i_report_valid) begin
            nxt_stats.frames    = sat_inc(stats.frames, 1'b1);
            nxt_stats.len_errs  = sat_inc(stats.len_errs, i_report.len_err);
            nxt_stats.gap_errs  = sat_inc(stats.gap_errs, i_report.gap_err);
            nxt_stats.code_errs = sat_inc(stats.code_errs, i_report.code_err);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stats <= '0;
        end else begin
            stats <= nxt_stats;
        end
    end

    assign o_stats = stats;

endmodule

`default_nettype wire

// ==== logic/xgmii_link_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_link_top (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_req_valid,
    input  xgmii_pkg::frame_req_t    i_req,
    output logic                     o_busy,
    output xgmii_pkg::xgmii_word_t   o_xgmii,
    output logic                     o_report_valid,
    output xgmii_pkg::frame_report_t o_report,
    output xgmii_pkg::link_stats_t   o_stats
);

    // Generator drives the lanes seen by the checker and the outside
    xgmii_frame_gen gen_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_busy      (o_busy),
        .o_xgmii     (o_xgmii)
    );

    xgmii_frame_checker chk_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_xgmii        (o_xgmii),
        .o_report_valid (o_report_valid),
        .o_report       (o_report)
    );

    xgmii_link_stats stats_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_report_valid (o_report_valid),
        .i_report       (o_report),
        .o_stats        (o_stats)
    );

endmodule

`default_nettype wire

// ==== dv/xgmii_tb_model.svh ====
`ifndef XGMII_TB_MODEL_SVH
`define XGMII_TB_MODEL_SVH

// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
endfunction

// Stream byte 0 is the start code, then len payload bytes, then the terminate
function automatic int frame_words(input frame_req_t r);
    return (int'(r.len) + 1) / 8 + 1;
endfunction

function automatic int term_tail(input frame_req_t r);
    return 7 - (int'(r.len) + 1) % 8;  // Idle lanes after the terminate
endfunction

function automatic int gap_words(input frame_req_t r);
    int t;
    t = term_tail(r);
    if (t >= int'(r.gap)) begin
        return 0;
    end
    return (int'(r.gap) - t + 7) / 8;
endfunction

function automatic xgmii_word_t expected_word(input frame_req_t r, input int w);
    xgmii_word_t x;
    int          b;
    int          p;
    for (int k = 0; k < 8; k++) begin
        b = 8 * w + k;
        p = b - 1;  // Payload index
        x.txc[k] = 1'b1;
        if (b == 0) begin
            x.txd[8*k +: 8] = START_CODE;
        end else if (b <= int'(r.len)) begin
            if (r.bad_code && p == int'(r.len) - 1) begin
                x.txd[8*k +: 8] = ERROR_CODE;
            end else begin
                x.txd[8*k +: 8] = r.seed + p[7:0];
                x.txc[k]        = 1'b0;
            end
        end else if (b == int'(r.len) + 1) begin
            x.txd[8*k +: 8] = TERM_CODE;
        end else begin
            x.txd[8*k +: 8] = IDLE_CODE;
        end
    end
    return x;
endfunction

function automatic frame_report_t expected_report(input frame_req_t r, input int gap_bytes,
                                                  input bit first);
    frame_report_t e;
    int            n;
    n = int'(r.len);
    e.len      = LEN_W'(n);
    e.len_err  = (n < MIN_PAYLOAD_BYTES) || (n > MAX_PAYLOAD_BYTES);
    e.code_err = r.bad_code;
    e.gap_err  = !first && (gap_bytes < MIN_GAP_BYTES);
    return e;
endfunction

task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    n_checks++;
    assert (got === exp) else begin
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        n_errors++;
    end
endtask

task automatic check_report();
    frame_report_t e;
    n_checks++;
    assert (exp_q.size() != 0) else begin
        $display("Report strobe at %0t ns with no frame outstanding", $time);
        n_errors++;
    end
    if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_value("o_report.len", o_report.len, e.len);
        check_value("o_report.len_err", o_report.len_err, e.len_err);
        check_value("o_report.code_err", o_report.code_err, e.code_err);
        check_value("o_report.gap_err", o_report.gap_err, e.gap_err);
    end
endtask

`endif

// ==== dv/xgmii_link_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmii_link_tb;
    import xgmii_pkg::*;

    localparam int TIMEOUT   = 4000;  // Cycles allowed per wait
    localparam int DRIVE_DLY = 10;

    logic          clk;
    logic          i_rst_n;
    logic          i_req_valid;
    frame_req_t    i_req;
    logic          o_busy;
    xgmii_word_t   o_xgmii;
    logic          o_report_valid;
    frame_report_t o_report;
    link_stats_t   o_stats;

    logic [31:0]   lfsr;
    int            n_checks;
    int            n_errors;
    frame_report_t exp_q[$];
    int            n_frames;
    int            n_len_errs;
    int            n_gap_errs;
    int            n_code_errs;
    int            late;       // Not-busy cycles after the first one, before the next strobe
    bit            between;
    bit            have_prev;
    int            prev_gap;   // Idle bytes the generator guarantees after the last frame

    `include "xgmii_tb_model.svh"

    xgmii_link_top dut_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_busy         (o_busy),
        .o_xgmii        (o_xgmii),
        .o_report_valid (o_report_valid),
        .o_report       (o_report),
        .o_stats        (o_stats)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One cycle; reports are checked whenever they show up
    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
        if (between) begin
            late++;
        end
        if (o_report_valid) begin
            check_report();
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_not_busy(input int exp_words);
        int c;
        c = 0;
        while (o_busy) begin
            step();
            c++;
            if (c > TIMEOUT) begin
                fail_timeout("o_busy low");
            end
        end
        check_value("o_busy idle words", 72'(c), 72'(exp_words));
    endtask

    task automatic drain_reports();
        int c;
        c = 0;
        while (exp_q.size() != 0) begin
            step();
            c++;
            if (c > TIMEOUT) begin
                fail_timeout("o_report_valid");
            end
        end
    endtask

    task automatic send_frame(input frame_req_t r, input int waits);
        frame_report_t e;
        repeat (waits) step();
        e = expected_report(r, prev_gap + 8 * late, !have_prev);
        exp_q.push_back(e);
        n_frames++;
        n_len_errs  += int'(e.len_err);
        n_gap_errs  += int'(e.gap_err);
        n_code_errs += int'(e.code_err);
        i_req       = r;
        i_req_valid = 1'b1;
        between     = 1'b0;
        step();
        i_req_valid = 1'b0;
        check_value("o_busy", o_busy, 1'b1);
        for (int w = 0; w < frame_words(r); w++) begin
            if (w > 0) begin
                step();
            end
            check_value("o_xgmii", o_xgmii, expected_word(r, w));
        end
        wait_not_busy(gap_words(r));
        prev_gap  = term_tail(r) + 8 * gap_words(r);
        have_prev = 1'b1;
        late      = 0;
        between   = 1'b1;
    endtask

    task automatic random_req(output frame_req_t r, output int waits, input bit allow_bad);
        r.len      = LEN_W'(take_bits(11) % 1581 + 20);
        r.gap      = 8'(take_bits(6) % 37 + 4);
        r.seed     = 8'(take_bits(8));
        r.bad_code = (take_bits(3) == 0) && allow_bad;  // One in eight
        waits      = take_bits(2);
    endtask

    task automatic run_random(input int n, input bit allow_bad);
        frame_req_t r;
        int         waits;
        repeat (n) begin
            random_req(r, waits, allow_bad);
            send_frame(r, waits);
        end
    endtask

    task automatic end_test(input string name, input int mark);
        $display("%-14s %s, %0d errors", name, (n_errors == mark) ? "ok" : "failing",
                 n_errors - mark);
    endtask

    initial begin
        frame_req_t r;
        int         waits;
        int         mark;
        int         dir_len[4];
        dir_len     = '{45, 46, 1500, 1501};
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        lfsr        = 32'd94206;
        n_checks    = 0;
        n_errors    = 0;
        n_frames    = 0;
        n_len_errs  = 0;
        n_gap_errs  = 0;
        n_code_errs = 0;
        late        = 0;
        between     = 1'b0;
        have_prev   = 1'b0;
        prev_gap    = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;

        mark = n_errors;
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_report_valid", o_report_valid, 1'b0);
        check_value("o_stats", o_stats, '0);
        check_value("o_xgmii", o_xgmii, {{8{IDLE_CODE}}, 8'hFF});
        end_test("reset", mark);

        mark = n_errors;
        run_random(40, 1'b0);
        drain_reports();
        end_test("frame format", mark);

        mark = n_errors;
        foreach (dir_len[i]) begin
            random_req(r, waits, 1'b0);
            r.len = LEN_W'(dir_len[i]);  // Limits and one past each
            send_frame(r, waits);
        end
        drain_reports();
        end_test("length", mark);

        mark = n_errors;
        run_random(20, 1'b0);
        drain_reports();
        end_test("gap", mark);

        mark = n_errors;
        run_random(40, 1'b1);
        drain_reports();
        step();  // Counters follow the last report by a cycle
        check_value("o_stats.frames", o_stats.frames, 16'(n_frames));
        check_value("o_stats.len_errs", o_stats.len_errs, 16'(n_len_errs));
        check_value("o_stats.gap_errs", o_stats.gap_errs, 16'(n_gap_errs));
        check_value("o_stats.code_errs", o_stats.code_errs, 16'(n_code_errs));
        end_test("code errors", mark);

        $display("Frames: %0d, checks: %0d, errors: %0d", n_frames, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
logic/xgmii_pkg.sv
logic/xgmii_frame_gen.sv
logic/xgmii_frame_checker.sv
logic/xgmii_link_stats.sv
logic/xgmii_link_top.sv
dv/xgmii_link_tb.sv
